//--- src/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef logic [31:0] instr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  regField_t;

    // field order matches the encoded word, msb first
    typedef struct packed {
        opcode_t   opcode;
        regField_t rs;
        regField_t rt;
        regField_t rd;
        regField_t shamt;
        funct_t    funct;
    } instrFields_t;

    //////////////////////////////
    // major opcodes
    //////////////////////////////
    localparam opcode_t OP_SPECIAL  = 6'b000000;
    localparam opcode_t OP_REGIMM   = 6'b000001;
    localparam opcode_t OP_J        = 6'b000010;
    localparam opcode_t OP_JAL      = 6'b000011;
    localparam opcode_t OP_BEQ      = 6'b000100;
    localparam opcode_t OP_BNE      = 6'b000101;
    localparam opcode_t OP_BLEZ     = 6'b000110;
    localparam opcode_t OP_BGTZ     = 6'b000111;
    localparam opcode_t OP_ADDI     = 6'b001000;
    localparam opcode_t OP_ADDIU    = 6'b001001;
    localparam opcode_t OP_SLTI     = 6'b001010;
    localparam opcode_t OP_SLTIU    = 6'b001011;
    localparam opcode_t OP_ANDI     = 6'b001100;
    localparam opcode_t OP_ORI      = 6'b001101;
    localparam opcode_t OP_XORI     = 6'b001110;
    localparam opcode_t OP_LUI      = 6'b001111;
    localparam opcode_t OP_SPECIAL2 = 6'b011100;
    localparam opcode_t OP_SPECIAL3 = 6'b011111;
    localparam opcode_t OP_LB       = 6'b100000;
    localparam opcode_t OP_LH       = 6'b100001;
    localparam opcode_t OP_LW       = 6'b100011;
    localparam opcode_t OP_SB       = 6'b101000;
    localparam opcode_t OP_SH       = 6'b101001;
    localparam opcode_t OP_SW       = 6'b101011;

    //////////////////////////////
    // SPECIAL funct codes
    //////////////////////////////
    // rotr and rotrv reuse the srl and srlv codes
    localparam funct_t FN_SLL   = 6'b000000;
    localparam funct_t FN_SRL   = 6'b000010;
    localparam funct_t FN_SRA   = 6'b000011;
    localparam funct_t FN_SLLV  = 6'b000100;
    localparam funct_t FN_SRLV  = 6'b000110;
    localparam funct_t FN_SRAV  = 6'b000111;
    localparam funct_t FN_JR    = 6'b001000;
    localparam funct_t FN_MOVZ  = 6'b001010;
    localparam funct_t FN_MOVN  = 6'b001011;
    localparam funct_t FN_MFHI  = 6'b010000;
    localparam funct_t FN_MTHI  = 6'b010001;
    localparam funct_t FN_MFLO  = 6'b010010;
    localparam funct_t FN_MTLO  = 6'b010011;
    localparam funct_t FN_MULT  = 6'b011000;
    localparam funct_t FN_MULTU = 6'b011001;
    localparam funct_t FN_ADD   = 6'b100000;
    localparam funct_t FN_ADDU  = 6'b100001;
    localparam funct_t FN_SUB   = 6'b100010;
    localparam funct_t FN_AND   = 6'b100100;
    localparam funct_t FN_OR    = 6'b100101;
    localparam funct_t FN_XOR   = 6'b100110;
    localparam funct_t FN_NOR   = 6'b100111;
    localparam funct_t FN_SLT   = 6'b101010;
    localparam funct_t FN_SLTU  = 6'b101011;

    // SPECIAL2 funct codes
    localparam funct_t FN_MADD  = 6'b000000;
    localparam funct_t FN_MUL   = 6'b000010;
    localparam funct_t FN_MSUB  = 6'b000100;

endpackage

`default_nettype wire

//--- src/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    typedef logic [5:0] aluOp_t;
    typedef logic [1:0] memSize_t;

    //////////////////////////////
    // ALU operation codes
    //////////////////////////////
    localparam aluOp_t ALU_ADD   = 6'b000000;
    localparam aluOp_t ALU_SUB   = 6'b000001;
    localparam aluOp_t ALU_MUL   = 6'b000010;
    localparam aluOp_t ALU_MULT  = 6'b000011;
    localparam aluOp_t ALU_MADD  = 6'b000100;
    localparam aluOp_t ALU_MSUB  = 6'b000101;
    localparam aluOp_t ALU_LUI   = 6'b000110;
    localparam aluOp_t ALU_BGEZ  = 6'b000111;
    localparam aluOp_t ALU_BEQ   = 6'b001000;
    localparam aluOp_t ALU_BNE   = 6'b001001;
    localparam aluOp_t ALU_BGTZ  = 6'b001010;
    localparam aluOp_t ALU_BLEZ  = 6'b001011;
    localparam aluOp_t ALU_BLTZ  = 6'b001100;
    localparam aluOp_t ALU_J     = 6'b001101;
    localparam aluOp_t ALU_JAL   = 6'b001110;
    localparam aluOp_t ALU_AND   = 6'b001111;
    localparam aluOp_t ALU_OR    = 6'b010000;
    localparam aluOp_t ALU_NOR   = 6'b010001;
    localparam aluOp_t ALU_XOR   = 6'b010010;
    localparam aluOp_t ALU_SEH   = 6'b010011;
    localparam aluOp_t ALU_SLL   = 6'b010100;
    localparam aluOp_t ALU_SRL   = 6'b010101;
    localparam aluOp_t ALU_MOVN  = 6'b010110;
    localparam aluOp_t ALU_MOVZ  = 6'b010111;
    localparam aluOp_t ALU_ROTR  = 6'b011000;
    localparam aluOp_t ALU_SRA   = 6'b011001;
    localparam aluOp_t ALU_SEB   = 6'b011010;
    localparam aluOp_t ALU_SLT   = 6'b011011;
    localparam aluOp_t ALU_MTHI  = 6'b011100;
    localparam aluOp_t ALU_MTLO  = 6'b011101;
    localparam aluOp_t ALU_MFHI  = 6'b011110;
    localparam aluOp_t ALU_MFLO  = 6'b011111;
    localparam aluOp_t ALU_ADDU  = 6'b100000;
    localparam aluOp_t ALU_MULTU = 6'b100001;
    localparam aluOp_t ALU_SLTU  = 6'b100010;
    localparam aluOp_t ALU_JR    = 6'b100011;

    // load/store access size
    localparam memSize_t MEM_WORD = 2'd0;
    localparam memSize_t MEM_HALF = 2'd1;
    localparam memSize_t MEM_BYTE = 2'd2;

    // datapath control word, 20 bits
    typedef struct packed {
        logic     aluSrc;
        logic     regDst;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     memToReg;
        logic     aluSft;
        logic     zeroSrc;
        logic     branch;
        logic     jalSrc;
        logic     jZeroSrc;
        logic     jrSrc;
        aluOp_t   aluOp;
        memSize_t semCtrl;
    } ctrlWord_t;

    // one decoder's answer, ctrl is zero unless hit
    typedef struct packed {
        logic      hit;
        ctrlWord_t ctrl;
    } decodeResult_t;

endpackage

`default_nettype wire

//--- src/rTypeDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module rTypeDecoder (
    input  wire isaPkg::instrFields_t    fields,
    output ctrlPkg::decodeResult_t       result
);

    ctrlPkg::aluOp_t aluOp;
    logic known;
    logic immShift;
    logic noWrite;
    logic isJr;

    // funct lookup
    always_comb begin
        aluOp = ctrlPkg::ALU_ADD;
        known = 1'b1;
        immShift = 1'b0;
        noWrite = 1'b0;
        isJr = 1'b0;
        case (fields.funct)
            isaPkg::FN_SLL: begin
                aluOp = ctrlPkg::ALU_SLL;
                immShift = 1'b1;
            end
            // rs bit 0 picks rotate
            isaPkg::FN_SRL: begin
                aluOp = fields.rs[0] ? ctrlPkg::ALU_ROTR : ctrlPkg::ALU_SRL;
                immShift = 1'b1;
            end
            isaPkg::FN_SRA: begin
                aluOp = ctrlPkg::ALU_SRA;
                immShift = 1'b1;
            end
            isaPkg::FN_SLLV:  aluOp = ctrlPkg::ALU_SLL;
            // variable form, shamt bit 0 picks rotate
            isaPkg::FN_SRLV:  aluOp = fields.shamt[0] ? ctrlPkg::ALU_ROTR : ctrlPkg::ALU_SRL;
            isaPkg::FN_SRAV:  aluOp = ctrlPkg::ALU_SRA;
            isaPkg::FN_ADD:   aluOp = ctrlPkg::ALU_ADD;
            isaPkg::FN_ADDU:  aluOp = ctrlPkg::ALU_ADDU;
            isaPkg::FN_SUB:   aluOp = ctrlPkg::ALU_SUB;
            isaPkg::FN_AND:   aluOp = ctrlPkg::ALU_AND;
            isaPkg::FN_OR:    aluOp = ctrlPkg::ALU_OR;
            isaPkg::FN_NOR:   aluOp = ctrlPkg::ALU_NOR;
            isaPkg::FN_XOR:   aluOp = ctrlPkg::ALU_XOR;
            isaPkg::FN_SLT:   aluOp = ctrlPkg::ALU_SLT;
            isaPkg::FN_SLTU:  aluOp = ctrlPkg::ALU_SLTU;
            isaPkg::FN_MOVN:  aluOp = ctrlPkg::ALU_MOVN;
            isaPkg::FN_MOVZ:  aluOp = ctrlPkg::ALU_MOVZ;
            isaPkg::FN_MFHI:  aluOp = ctrlPkg::ALU_MFHI;
            isaPkg::FN_MFLO:  aluOp = ctrlPkg::ALU_MFLO;
            // these only touch HI/LO
            isaPkg::FN_MULT: begin
                aluOp = ctrlPkg::ALU_MULT;
                noWrite = 1'b1;
            end
            isaPkg::FN_MULTU: begin
                aluOp = ctrlPkg::ALU_MULTU;
                noWrite = 1'b1;
            end
            isaPkg::FN_MTHI: begin
                aluOp = ctrlPkg::ALU_MTHI;
                noWrite = 1'b1;
            end
            isaPkg::FN_MTLO: begin
                aluOp = ctrlPkg::ALU_MTLO;
                noWrite = 1'b1;
            end
            isaPkg::FN_JR: begin
                aluOp = ctrlPkg::ALU_JR;
                isJr = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        result = '0;
        if (fields.opcode == isaPkg::OP_SPECIAL && known) begin
            result.hit = 1'b1;
            result.ctrl.aluOp = aluOp;
            result.ctrl.jalSrc = 1'b1;
            if (isJr) begin
                result.ctrl.branch = 1'b1;
                result.ctrl.jrSrc = 1'b1;
            end else begin
                result.ctrl.regDst = 1'b1;
                result.ctrl.regWrite = ~noWrite;
                result.ctrl.memToReg = 1'b1;
                result.ctrl.aluSft = immShift;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/multExtendDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module multExtendDecoder (
    input  wire isaPkg::instrFields_t    fields,
    output ctrlPkg::decodeResult_t       result
);

    always_comb begin
        result = '0;
        if (fields.opcode == isaPkg::OP_SPECIAL2) begin
            // register-format pattern, then per funct
            result.hit = 1'b1;
            result.ctrl.regDst = 1'b1;
            result.ctrl.regWrite = 1'b1;
            result.ctrl.memToReg = 1'b1;
            result.ctrl.jalSrc = 1'b1;
            case (fields.funct)
                isaPkg::FN_MUL: result.ctrl.aluOp = ctrlPkg::ALU_MUL;
                // accumulate into HI/LO only
                isaPkg::FN_MADD: begin
                    result.ctrl.aluOp = ctrlPkg::ALU_MADD;
                    result.ctrl.regWrite = 1'b0;
                end
                isaPkg::FN_MSUB: begin
                    result.ctrl.aluOp = ctrlPkg::ALU_MSUB;
                    result.ctrl.regWrite = 1'b0;
                end
                default: result = '0;
            endcase
        end else if (fields.opcode == isaPkg::OP_SPECIAL3) begin
            result.hit = 1'b1;
            result.ctrl.regDst = 1'b1;
            result.ctrl.regWrite = 1'b1;
            result.ctrl.memToReg = 1'b1;
            result.ctrl.jalSrc = 1'b1;
            // shamt bit 3 separates halfword from byte
            result.ctrl.aluOp = fields.shamt[3] ? ctrlPkg::ALU_SEH : ctrlPkg::ALU_SEB;
        end
    end

endmodule

`default_nettype wire

//--- src/iTypeDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module iTypeDecoder (
    input  wire isaPkg::instrFields_t    fields,
    output ctrlPkg::decodeResult_t       result
);

    ctrlPkg::aluOp_t aluOp;
    ctrlPkg::memSize_t size;
    logic known;
    logic zeroSrc;
    logic isLoad;
    logic isStore;

    always_comb begin
        aluOp = ctrlPkg::ALU_ADD;
        size = ctrlPkg::MEM_WORD;
        known = 1'b1;
        zeroSrc = 1'b0;
        isLoad = 1'b0;
        isStore = 1'b0;
        case (fields.opcode)
            isaPkg::OP_ADDI:  aluOp = ctrlPkg::ALU_ADD;
            isaPkg::OP_ADDIU: aluOp = ctrlPkg::ALU_ADDU;
            isaPkg::OP_SLTI:  aluOp = ctrlPkg::ALU_SLT;
            isaPkg::OP_LUI:   aluOp = ctrlPkg::ALU_LUI;
            // zero-extended immediates
            isaPkg::OP_SLTIU: begin
                aluOp = ctrlPkg::ALU_SLTU;
                zeroSrc = 1'b1;
            end
            isaPkg::OP_ANDI: begin
                aluOp = ctrlPkg::ALU_AND;
                zeroSrc = 1'b1;
            end
            isaPkg::OP_ORI: begin
                aluOp = ctrlPkg::ALU_OR;
                zeroSrc = 1'b1;
            end
            isaPkg::OP_XORI: begin
                aluOp = ctrlPkg::ALU_XOR;
                zeroSrc = 1'b1;
            end
            // address add for all memory ops
            isaPkg::OP_LW:    isLoad = 1'b1;
            isaPkg::OP_LH: begin
                isLoad = 1'b1;
                size = ctrlPkg::MEM_HALF;
            end
            isaPkg::OP_LB: begin
                isLoad = 1'b1;
                size = ctrlPkg::MEM_BYTE;
            end
            isaPkg::OP_SW:    isStore = 1'b1;
            isaPkg::OP_SH: begin
                isStore = 1'b1;
                size = ctrlPkg::MEM_HALF;
            end
            isaPkg::OP_SB: begin
                isStore = 1'b1;
                size = ctrlPkg::MEM_BYTE;
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        result = '0;
        if (known) begin
            result.hit = 1'b1;
            result.ctrl.aluSrc = 1'b1;
            result.ctrl.jalSrc = 1'b1;
            result.ctrl.aluOp = aluOp;
            result.ctrl.zeroSrc = zeroSrc;
            result.ctrl.semCtrl = size;
            result.ctrl.memRead = isLoad;
            result.ctrl.memWrite = isStore;
            result.ctrl.regWrite = ~isStore;
            // loads write back from memory, not the ALU
            result.ctrl.memToReg = ~(isLoad | isStore);
        end
    end

endmodule

`default_nettype wire

//--- src/branchDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module branchDecoder (
    input  wire isaPkg::instrFields_t    fields,
    output ctrlPkg::decodeResult_t       result
);

    ctrlPkg::aluOp_t aluOp;
    logic known;
    logic condBranch;
    logic isJal;

    always_comb begin
        aluOp = ctrlPkg::ALU_J;
        known = 1'b1;
        condBranch = 1'b0;
        isJal = 1'b0;
        case (fields.opcode)
            // rt selects the regimm compare
            isaPkg::OP_REGIMM: begin
                condBranch = 1'b1;
                if (fields.rt == 5'd1) begin
                    aluOp = ctrlPkg::ALU_BGEZ;
                end else if (fields.rt == 5'd0) begin
                    aluOp = ctrlPkg::ALU_BLTZ;
                end else begin
                    known = 1'b0;
                end
            end
            isaPkg::OP_BEQ: begin
                aluOp = ctrlPkg::ALU_BEQ;
                condBranch = 1'b1;
            end
            isaPkg::OP_BNE: begin
                aluOp = ctrlPkg::ALU_BNE;
                condBranch = 1'b1;
            end
            isaPkg::OP_BGTZ: begin
                aluOp = ctrlPkg::ALU_BGTZ;
                condBranch = 1'b1;
            end
            isaPkg::OP_BLEZ: begin
                aluOp = ctrlPkg::ALU_BLEZ;
                condBranch = 1'b1;
            end
            isaPkg::OP_J:     aluOp = ctrlPkg::ALU_J;
            isaPkg::OP_JAL: begin
                aluOp = ctrlPkg::ALU_JAL;
                isJal = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        result = '0;
        if (known) begin
            result.hit = 1'b1;
            result.ctrl.branch = 1'b1;
            result.ctrl.aluOp = aluOp;
            result.ctrl.jZeroSrc = condBranch;
            // jal writes the link register, jalSrc low selects it
            result.ctrl.jalSrc = ~isJal;
            result.ctrl.regWrite = isJal;
            result.ctrl.memToReg = isJal;
        end
    end

endmodule

`default_nettype wire

//--- src/controlSelect.sv
`timescale 1ns/1ps
`default_nettype none

module controlSelect (
    input  wire                          clk,
    input  wire                          reset,
    input  wire isaPkg::instr_t          instruction,
    input  wire ctrlPkg::decodeResult_t  rResult,
    input  wire ctrlPkg::decodeResult_t  mxResult,
    input  wire ctrlPkg::decodeResult_t  iResult,
    input  wire ctrlPkg::decodeResult_t  bResult,
    output ctrlPkg::ctrlWord_t           ctrl
);

    ctrlPkg::ctrlWord_t nextCtrl;

    // nop beats the sll match from the R-type decoder
    always_comb begin
        nextCtrl = '0;
        if (instruction == '0) begin
            nextCtrl.jalSrc = 1'b1;
            nextCtrl.aluOp = ctrlPkg::ALU_ADD;
        end else if (rResult.hit) begin
            nextCtrl = rResult.ctrl;
        end else if (mxResult.hit) begin
            nextCtrl = mxResult.ctrl;
        end else if (iResult.hit) begin
            nextCtrl = iResult.ctrl;
        end else if (bResult.hit) begin
            nextCtrl = bResult.ctrl;
        end
    end

    //////////////////////////////
    // decode stage register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= '0;
        end else begin
            ctrl <= nextCtrl;
        end
    end

endmodule

`default_nettype wire

//--- src/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
    input  wire                  clk,
    input  wire                  reset,
    input  wire isaPkg::instr_t  instruction,
    output ctrlPkg::ctrlWord_t   ctrl
);

    isaPkg::instrFields_t fields;
    ctrlPkg::decodeResult_t rResult;
    ctrlPkg::decodeResult_t mxResult;
    ctrlPkg::decodeResult_t iResult;
    ctrlPkg::decodeResult_t bResult;

    assign fields = isaPkg::instrFields_t'(instruction);

    // one decoder per instruction class
    rTypeDecoder u_rTypeDecoder (.fields(fields), .result(rResult));
    multExtendDecoder u_multExtendDecoder (.fields(fields), .result(mxResult));
    iTypeDecoder u_iTypeDecoder (.fields(fields), .result(iResult));
    branchDecoder u_branchDecoder (.fields(fields), .result(bResult));

    controlSelect u_controlSelect (
        .clk(clk),
        .reset(reset),
        .instruction(instruction),
        .rResult(rResult),
        .mxResult(mxResult),
        .iResult(iResult),
        .bResult(bResult),
        .ctrl(ctrl)
    );

endmodule

`default_nettype wire

//--- tb/controlDecoderTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecoderTb;

    localparam int    RESET_CYCLES = 16;
    localparam string CASE_FILE    = "tb/controlCases.txt";

    logic               clk;
    logic               reset;
    isaPkg::instr_t     instruction;
    ctrlPkg::ctrlWord_t ctrl;

    // case table, filled from the data file
    string              caseName[$];
    isaPkg::instr_t     caseInstr[$];
    ctrlPkg::ctrlWord_t caseExpect[$];

    // word registered on the last rising edge
    ctrlPkg::ctrlWord_t prevExpect;

    int cycleCount = 0;
    int cycleLimit = 1000;

    controlDecoder u_controlDecoder (
        .clk(clk),
        .reset(reset),
        .instruction(instruction),
        .ctrl(ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // run limit
    //////////////////////////////
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("sim failed");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    task automatic loadCases();
        int fd;
        int code;
        logic [8*160-1:0] lineBuf;
        string name;
        logic [31:0] instrVal;
        logic [19:0] expVal;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the case file %s", CASE_FILE);
            $display("sim failed");
            $fatal(1, "case file missing");
        end
        while (!$feof(fd)) begin
            lineBuf = '0;
            code = $fgets(lineBuf, fd);
            if (code > 0) begin
                name = "";
                code = $sscanf(lineBuf, "%s %h %h", name, instrVal, expVal);
                // skip blank and comment lines
                if (code >= 1 && name.len() > 0 && name.getc(0) != "#") begin
                    if (code != 3) begin
                        $display("case line for %s is malformed", name);
                        $display("sim failed");
                        $fatal(1, "bad case line");
                    end
                    caseName.push_back(name);
                    caseInstr.push_back(instrVal);
                    caseExpect.push_back(ctrlPkg::ctrlWord_t'(expVal));
                end
            end
        end
        $fclose(fd);
        if (caseName.size() == 0) begin
            $display("the case file %s holds no cases", CASE_FILE);
            $display("sim failed");
            $fatal(1, "no cases");
        end
    endtask

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic checkCtrl(input string name, input ctrlPkg::ctrlWord_t expected,
                             input ctrlPkg::ctrlWord_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s ctrl expected %05h actual %05h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "control word mismatch");
        end
    endtask

    // operation field alone, as a 6-bit code
    task automatic checkAluOp(input string name, input ctrlPkg::aluOp_t expected,
                              input ctrlPkg::aluOp_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s aluOp expected %02h actual %02h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "ALU operation mismatch");
        end
    endtask

    initial begin
        void'($urandom(32'hec4c_2c4c));
        reset = 1'b1;
        // nonzero so reset has something to hold off
        instruction = 32'h0064_1020;
        prevExpect = '0;
        loadCases();
        cycleLimit = RESET_CYCLES + 2 * caseName.size() + 20;

        // ctrl stays zero while reset is sampled high
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            checkCtrl("reset", '0, ctrl);
        end
        reset = 1'b0;

        // back to back, one instruction per cycle
        for (int i = 0; i < caseName.size(); i++) begin
            instruction = caseInstr[i];
            // mid low phase, the previous word is still registered
            #10;
            checkCtrl({caseName[i], " before edge"}, prevExpect, ctrl);
            @(posedge clk);
            @(negedge clk);
            checkAluOp(caseName[i], caseExpect[i].aluOp, ctrl.aluOp);
            checkCtrl(caseName[i], caseExpect[i], ctrl);
            prevExpect = caseExpect[i];
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
src/isaPkg.sv
src/ctrlPkg.sv
src/rTypeDecoder.sv
src/multExtendDecoder.sv
src/iTypeDecoder.sv
src/branchDecoder.sv
src/controlSelect.sv
src/controlDecoder.sv
tb/controlDecoderTb.sv

//--- tb/controlCases.txt
# columns: case name, instruction word (hex), expected 20-bit control word (hex)
# word bits msb first: flags aluSrc..jrSrc, aluOp[7:2], semCtrl[1:0]
# R-type immediate shifts
sll         00031100 66450
srl         00031102 66454
rotr        00231102 66460
sra         00031103 66464
# R-type variable shifts
sllv        00831004 64450
srlv        00831006 64454
rotrv       00831046 64460
srav        00831007 64464
# R-type arithmetic and logic
add         00641020 64400
addu        00641021 64480
sub         00641022 64404
and         00641024 6443c
or          00641025 64440
xor         00641026 64448
nor         00641027 64444
slt         0064102a 6446c
sltu        0064102b 64488
movn        0064100b 64458
movz        0064100a 6445c
# HI/LO moves and multiplies
mfhi        00001010 64478
mflo        00001012 6447c
mult        00640018 4440c
multu       00640019 44484
mthi        00600011 44470
mtlo        00600013 44474
jr          03e00008 00d8c
# SPECIAL2 and SPECIAL3
mul         70641002 64408
madd        70640000 44410
msub        70640004 44414
seh         7c031620 6444c
seb         7c031420 64468
# I-type arithmetic and logic
addi        20620005 a4400
addiu       24620005 a4480
slti        28620005 a446c
sltiu       2c620005 a5488
andi        30620005 a543c
ori         34620005 a5440
xori        38620005 a5448
lui         3c021234 a4418
# loads and stores
lw          8c620008 b0400
lh          84620008 b0401
lb          80620008 b0402
sw          ac620008 88400
sh          a4620008 88401
sb          a0620008 88402
# branches and jumps
bgez        04610004 00e1c
bltz        04600004 00e30
beq         10620004 00e20
bne         14620004 00e24
blez        18600004 00e2c
bgtz        1c600004 00e28
j           08000010 00c34
jal         0c000010 24838
# nop and encodings that decode to nothing
nop         00000000 00400
opUnknown   fc000000 00000
cop0        40000000 00000
fnUnknown   0064103f 00000
regimmRt2   04620004 00000
sp2Fn08     70641008 00000
sp2Fn09     70641009 00000
sp2Fn3f     7064103f 00000
# nop right after a decoded word
addAgain    00641020 64400
nopAgain    00000000 00400
